// File: src.f
rtl/screenPkg.sv
rtl/panelPkg.sv
rtl/touchDecode.sv
rtl/tileTimers.sv
rtl/touchHistory.sv
rtl/colourHistogram.sv
rtl/tilePainter.sv
rtl/panelControl.sv
rtl/colourTileBoard.sv
verification/colourTileBoardTb.sv

// File: Makefile
# Verilator build of the colour tile board testbench

SOURCES := $(shell cat src.f)

obj_dir/VcolourTileBoardTb: src.f $(SOURCES)
	verilator --binary --timing --top-module colourTileBoardTb -f src.f -o VcolourTileBoardTb

run: obj_dir/VcolourTileBoardTb
	./obj_dir/VcolourTileBoardTb

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: verification/colourTileBoardTb.sv
// colour tile board testbench
// drives touches, pixel requests and the mode level, keeps a cycle model
// of the board and compares segments and RGB on every falling edge

`timescale 1ns/1ps

module colourTileBoardTb;

	localparam int tickCycles = 20;
	// phase lengths in cycles
	localparam int idleLength = 80;
	localparam int touchCount = 48;
	localparam int modeTouches = 24;
	localparam int pixelCycles = 200;
	localparam int testCycles = 8 + 12 + idleLength + (touchCount + touchCount / 6) * 4
		+ 1 + (modeTouches + modeTouches / 6) * 4 + 40 + 11 + pixelCycles + 2;

	logic Clock;
	logic Resetn;
	logic touchValid;
	panelPkg::touchCoord touchX;
	panelPkg::touchCoord touchY;
	screenPkg::pixelCoord pixelX;
	screenPkg::pixelCoord pixelY;
	screenPkg::colourLevel pixelRed;
	screenPkg::colourLevel pixelGreen;
	screenPkg::colourLevel pixelBlue;
	logic histogramMode;
	panelPkg::segmentPattern segmentsN [panelPkg::digitCount];

	// cycle model state
	logic hitValidModel;
	logic [2:0] hitTileModel;
	int timerModel [8];
	logic [2:0] colourModel [8];
	logic [4:0] histModel [8];
	logic [4:0] countModel [8];
	logic [6:0] segModel [8];
	logic [23:0] rgbModel;
	logic modeModel;
	logic [31:0] lfsrState;

	colourTileBoard #(
		.TickCycles(tickCycles)
	) dut (
		.Clock(Clock),
		.Resetn(Resetn),
		.touchValid(touchValid),
		.touchX(touchX),
		.touchY(touchY),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelRed(pixelRed),
		.pixelGreen(pixelGreen),
		.pixelBlue(pixelBlue),
		.histogramMode(histogramMode),
		.segmentsN(segmentsN)
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken
	task automatic drawBits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	// active low gfedcba, codes 16 and up blank
	function automatic logic [6:0] expectedSegments(input logic [4:0] code);
		if (code[4]) begin
			return 7'h7F;
		end
		case (code[3:0])
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'hA: return 7'h08;
			4'hB: return 7'h03;
			4'hC: return 7'h46;
			4'hD: return 7'h21;
			4'hE: return 7'h06;
			default: return 7'h0E;
		endcase
	endfunction

	// back from a pattern to its hex value, -1 if none
	function automatic int decodeSegments(input logic [6:0] pattern);
		for (int v = 0; v < 16; v++) begin
			if (expectedSegments(5'(v)) == pattern) begin
				return v;
			end
		end
		return -1;
	endfunction

	// {red, green, blue} from the model colours
	function automatic logic [23:0] expectedRgb(input logic [9:0] x, input logic [9:0] y);
		int col;
		logic row;
		logic [2:0] c;
		if (x >= 10'd800 || y >= 10'd480) begin
			return '0;
		end
		col = int'(x) / 200;
		row = (y >= 10'd240);
		c = colourModel[{row, col[1:0]}];
		return {{8{c[2]}}, {8{c[1]}}, {8{c[0]}}};
	endfunction

	function automatic logic [4:0] countColour(input logic [2:0] c);
		logic [4:0] n;
		n = '0;
		for (int t = 0; t < 8; t++) begin
			if (colourModel[t] == c) begin
				n = n + 5'd1;
			end
		end
		return n;
	endfunction

	// next model state, all from values before the edge
	always @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			hitValidModel <= 1'b0;
			hitTileModel <= '0;
			rgbModel <= '0;
			modeModel <= 1'b0;
			for (int i = 0; i < 8; i++) begin
				timerModel[i] <= 0;
				colourModel[i] <= 3'(i);
				histModel[i] <= 5'h1F;
				countModel[i] <= '0;
				segModel[i] <= 7'h7F;
			end
		end else begin
			hitValidModel <= touchValid;
			hitTileModel <= {touchY[11], touchX[11:10]};
			modeModel <= histogramMode;
			for (int i = 0; i < 8; i++) begin
				// a timeout still steps the colour on a touch cycle
				if (timerModel[i] == tickCycles - 1) begin
					timerModel[i] <= 0;
					colourModel[i] <= colourModel[i] + 3'd1;
				end else if (hitValidModel) begin
					if (hitTileModel == 3'(i)) begin
						timerModel[i] <= 0;
					end
				end else begin
					timerModel[i] <= timerModel[i] + 1;
				end
				countModel[i] <= countColour(3'(i));
				segModel[i] <= expectedSegments(histogramMode ? countModel[i] : histModel[i]);
			end
			// distinct touches only, frozen in histogram mode
			if (hitValidModel && !histogramMode && histModel[0] != {2'b00, hitTileModel}) begin
				for (int i = 7; i > 0; i--) begin
					histModel[i] <= histModel[i - 1];
				end
				histModel[0] <= {2'b00, hitTileModel};
			end
			rgbModel <= expectedRgb(pixelX, pixelY);
		end
	end

	task automatic compareValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERR time=%0t signal=%s actual=%h expected=%h", $time, name, actual,
				expected);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// outputs are settled half a cycle after the edge
	always @(negedge Clock) begin
		int sum;
		sum = 0;
		for (int d = 0; d < 8; d++) begin
			sum = sum + decodeSegments(segmentsN[d]);
		end
		// eight tiles spread over the colour counts
		if (Resetn && modeModel) begin
			compareValue("countSum", 32'(sum), 32'd8);
		end
		for (int d = 0; d < 8; d++) begin
			compareValue($sformatf("segmentsN[%0d]", d), 32'(segmentsN[d]), 32'(segModel[d]));
		end
		compareValue("pixelRed", 32'(pixelRed), 32'(rgbModel[23:16]));
		compareValue("pixelGreen", 32'(pixelGreen), 32'(rgbModel[15:8]));
		compareValue("pixelBlue", 32'(pixelBlue), 32'(rgbModel[7:0]));
	end

	task automatic randomPixel();
		logic [31:0] x;
		logic [31:0] y;
		drawBits(10, x);
		drawBits(10, y);
		pixelX <= x[9:0];
		pixelY <= y[9:0];
	endtask

	task automatic idleFor(input int n);
		repeat (n) begin
			@(posedge Clock);
			touchValid <= 1'b0;
			randomPixel();
		end
	endtask

	// one-cycle strobe somewhere inside the tile
	task automatic pressTile(input logic [2:0] tile);
		logic [31:0] xLow;
		logic [31:0] yLow;
		drawBits(10, xLow);
		drawBits(11, yLow);
		@(posedge Clock);
		touchValid <= 1'b1;
		touchX <= {tile[1:0], xLow[9:0]};
		touchY <= {tile[2], yLow[10:0]};
		randomPixel();
		idleFor(3);
	endtask

	// centre pixel of a tile
	task automatic probeTile(input int tile);
		@(posedge Clock);
		pixelX <= 10'((tile % 4) * 200 + 100);
		pixelY <= 10'((tile / 4) * 240 + 120);
	endtask

	task automatic touchRound(input int n);
		logic [31:0] tile;
		for (int k = 0; k < n; k++) begin
			drawBits(3, tile);
			pressTile(tile[2:0]);
			// same tile again, no shift expected
			if (k % 6 == 5) begin
				pressTile(tile[2:0]);
			end
		end
	endtask

	initial begin
		lfsrState = 32'h45e9_7c96;
		Resetn <= 1'b0;
		touchValid <= 1'b0;
		touchX <= '0;
		touchY <= '0;
		pixelX <= '0;
		pixelY <= '0;
		histogramMode <= 1'b0;
		repeat (8) @(posedge Clock);
		Resetn <= 1'b1;
		// tile i still shows colour i
		for (int t = 0; t < 8; t++) begin
			probeTile(t);
		end
		idleFor(4);
		idleFor(idleLength);
		touchRound(touchCount);
		@(posedge Clock);
		histogramMode <= 1'b1;
		touchRound(modeTouches);
		idleFor(40);
		@(posedge Clock);
		histogramMode <= 1'b0;
		idleFor(10);
		idleFor(pixelCycles);
		idleFor(2);
		$display("TEST OK");
		$finish;
	end

	initial begin
		#((testCycles + 100) * 100);
		$display("watchdog expired before the test sequence finished");
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

endmodule

// File: rtl/colourTileBoard.sv
// colour tile board top level
// eight timed colour tiles on a touch screen, with touch history
// and colour histogram shown on eight seven-segment digits

`timescale 1ns/1ps

module colourTileBoard #(
	parameter int unsigned TickCycles = panelPkg::defaultTickCycles
) (
	input logic Clock,
	input logic Resetn,
	input logic touchValid,
	input panelPkg::touchCoord touchX,
	input panelPkg::touchCoord touchY,
	input screenPkg::pixelCoord pixelX,
	input screenPkg::pixelCoord pixelY,
	output screenPkg::colourLevel pixelRed,
	output screenPkg::colourLevel pixelGreen,
	output screenPkg::colourLevel pixelBlue,
	input logic histogramMode,
	output panelPkg::segmentPattern segmentsN [panelPkg::digitCount]
);

	logic hitValid;
	screenPkg::tileIndex hitTile;
	screenPkg::tileColour tileColours [screenPkg::tileCount];
	panelPkg::digitCode historyDigits [panelPkg::digitCount];
	panelPkg::digitCode countDigits [panelPkg::digitCount];

	touchDecode touchDecodeUnit (
		.Clock(Clock),
		.Resetn(Resetn),
		.touchValid(touchValid),
		.touchX(touchX),
		.touchY(touchY),
		.hitValid(hitValid),
		.hitTile(hitTile)
	);

	tileTimers #(
		.TickCycles(TickCycles)
	) tileTimersUnit (
		.Clock(Clock),
		.Resetn(Resetn),
		.hitValid(hitValid),
		.hitTile(hitTile),
		.tileColours(tileColours)
	);

	touchHistory touchHistoryUnit (
		.Clock(Clock),
		.Resetn(Resetn),
		.hitValid(hitValid),
		.hitTile(hitTile),
		.histogramMode(histogramMode),
		.historyDigits(historyDigits)
	);

	colourHistogram colourHistogramUnit (
		.Clock(Clock),
		.Resetn(Resetn),
		.tileColours(tileColours),
		.countDigits(countDigits)
	);

	// display controller side
	tilePainter tilePainterUnit (
		.Clock(Clock),
		.Resetn(Resetn),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.tileColours(tileColours),
		.pixelRed(pixelRed),
		.pixelGreen(pixelGreen),
		.pixelBlue(pixelBlue)
	);

	panelControl panelControlUnit (
		.Clock(Clock),
		.Resetn(Resetn),
		.histogramMode(histogramMode),
		.historyDigits(historyDigits),
		.countDigits(countDigits),
		.segmentsN(segmentsN)
	);

endmodule

// File: rtl/panelControl.sv
// panel control
// picks history or colour counts for the eight digits and encodes them
// into registered active-low segment patterns

`timescale 1ns/1ps

module panelControl (
	input logic Clock,
	input logic Resetn,
	input logic histogramMode,
	input panelPkg::digitCode historyDigits [panelPkg::digitCount],
	input panelPkg::digitCode countDigits [panelPkg::digitCount],
	output panelPkg::segmentPattern segmentsN [panelPkg::digitCount]
);

	// codes 16 and up show nothing
	function automatic panelPkg::segmentPattern glyphFor(input panelPkg::digitCode code);
		if (code[4]) begin
			return '1;
		end
		return panelPkg::hexGlyph[code[3:0]];
	endfunction

	panelPkg::digitCode shown [panelPkg::digitCount];

	// mode selects the source for all digits at once
	always_comb begin
		for (int d = 0; d < panelPkg::digitCount; d++) begin
			shown[d] = histogramMode ? countDigits[d] : historyDigits[d];
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			// all segments off
			for (int d = 0; d < panelPkg::digitCount; d++) begin
				segmentsN[d] <= '1;
			end
		end else begin
			for (int d = 0; d < panelPkg::digitCount; d++) begin
				segmentsN[d] <= glyphFor(shown[d]);
			end
		end
	end

endmodule

// File: rtl/tilePainter.sv
// tile painter
// answers a pixel request with the RGB of the tile under it, one cycle later
// pixels beyond the 800x480 area are black

`timescale 1ns/1ps

module tilePainter (
	input logic Clock,
	input logic Resetn,
	input screenPkg::pixelCoord pixelX,
	input screenPkg::pixelCoord pixelY,
	input screenPkg::tileColour tileColours [screenPkg::tileCount],
	output screenPkg::colourLevel pixelRed,
	output screenPkg::colourLevel pixelGreen,
	output screenPkg::colourLevel pixelBlue
);

	logic [1:0] column;
	logic row;
	logic onScreen;
	screenPkg::tileColour colour;

	// column in 200 pixel steps
	always_comb begin
		if (pixelX < screenPkg::tileWidth) begin
			column = 2'd0;
		end else if (pixelX < screenPkg::pixelCoord'(2 * screenPkg::tileWidth)) begin
			column = 2'd1;
		end else if (pixelX < screenPkg::pixelCoord'(3 * screenPkg::tileWidth)) begin
			column = 2'd2;
		end else begin
			column = 2'd3;
		end
	end

	// lower row from line 240
	assign row = (pixelY >= screenPkg::tileHeight);
	assign onScreen = (pixelX < screenPkg::screenWidth) && (pixelY < screenPkg::screenHeight);
	assign colour = tileColours[{row, column}];

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			pixelRed <= '0;
			pixelGreen <= '0;
			pixelBlue <= '0;
		end else begin
			// each colour bit spread over the full channel
			pixelRed <= {$bits(screenPkg::colourLevel){colour[2] & onScreen}};
			pixelGreen <= {$bits(screenPkg::colourLevel){colour[1] & onScreen}};
			pixelBlue <= {$bits(screenPkg::colourLevel){colour[0] & onScreen}};
		end
	end

endmodule

// File: rtl/colourHistogram.sv
// colour histogram
// registered count of tiles showing each colour value

`timescale 1ns/1ps

module colourHistogram (
	input logic Clock,
	input logic Resetn,
	input screenPkg::tileColour tileColours [screenPkg::tileCount],
	output panelPkg::digitCode countDigits [panelPkg::digitCount]
);

	// 0 to 8 tiles per colour
	logic [3:0] counts [panelPkg::digitCount];

	// one digit per colour value
	always_comb begin
		for (int c = 0; c < panelPkg::digitCount; c++) begin
			counts[c] = '0;
			for (int t = 0; t < screenPkg::tileCount; t++) begin
				counts[c] = counts[c] + 4'(tileColours[t] == screenPkg::tileColour'(c));
			end
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			for (int c = 0; c < panelPkg::digitCount; c++) begin
				countDigits[c] <= '0;
			end
		end else begin
			for (int c = 0; c < panelPkg::digitCount; c++) begin
				countDigits[c] <= panelPkg::digitCode'(counts[c]);
			end
		end
	end

endmodule

// File: rtl/touchHistory.sv
// touch history
// last eight distinct touched tiles, newest in entry 0
// frozen while histogram mode is on

`timescale 1ns/1ps

module touchHistory (
	input logic Clock,
	input logic Resetn,
	input logic hitValid,
	input screenPkg::tileIndex hitTile,
	input logic histogramMode,
	output panelPkg::digitCode historyDigits [panelPkg::digitCount]
);

	panelPkg::digitCode hitCode;
	logic shiftIn;

	assign hitCode = panelPkg::digitCode'(hitTile);

	// a blank entry 0 never equals a tile code
	assign shiftIn = hitValid && !histogramMode && (historyDigits[0] != hitCode);

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			for (int i = 0; i < panelPkg::digitCount; i++) begin
				historyDigits[i] <= panelPkg::blankDigit;
			end
		end else if (shiftIn) begin
			// oldest entry drops off the end
			for (int i = panelPkg::digitCount - 1; i > 0; i--) begin
				historyDigits[i] <= historyDigits[i - 1];
			end
			historyDigits[0] <= hitCode;
		end
	end

endmodule

// File: rtl/tileTimers.sv
// tile timers
// one period counter and one colour per tile, colour steps on each timeout
// a touch restarts the touched tile and holds the rest for that cycle

`timescale 1ns/1ps

module tileTimers #(
	parameter int unsigned TickCycles = panelPkg::defaultTickCycles
) (
	input logic Clock,
	input logic Resetn,
	input logic hitValid,
	input screenPkg::tileIndex hitTile,
	output screenPkg::tileColour tileColours [screenPkg::tileCount]
);

	localparam int TimerWidth = $clog2(TickCycles);

	logic [TimerWidth-1:0] timers [screenPkg::tileCount];
	logic terminal [screenPkg::tileCount];

	// last count of the period
	always_comb begin
		for (int i = 0; i < screenPkg::tileCount; i++) begin
			terminal[i] = (timers[i] == TimerWidth'(TickCycles - 1));
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			for (int i = 0; i < screenPkg::tileCount; i++) begin
				timers[i] <= '0;
				// tile i starts at colour i
				tileColours[i] <= screenPkg::tileColour'(i);
			end
		end else begin
			for (int i = 0; i < screenPkg::tileCount; i++) begin
				if (terminal[i]) begin
					// timeout wins over a touch, colour wraps 7 to 0
					timers[i] <= '0;
					tileColours[i] <= tileColours[i] + screenPkg::tileColour'(1);
				end else if (hitValid) begin
					// touched tile restarts, others stand still
					if (hitTile == screenPkg::tileIndex'(i)) begin
						timers[i] <= '0;
					end
				end else begin
					timers[i] <= timers[i] + TimerWidth'(1);
				end
			end
		end
	end

endmodule

// File: rtl/touchDecode.sv
// touch decode
// registers the touch strobe and maps panel coordinates to a tile index

`timescale 1ns/1ps

module touchDecode (
	input logic Clock,
	input logic Resetn,
	input logic touchValid,
	input panelPkg::touchCoord touchX,
	input panelPkg::touchCoord touchY,
	output logic hitValid,
	output screenPkg::tileIndex hitTile
);

	// strobe is delayed one cycle
	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			hitValid <= 1'b0;
		end else begin
			hitValid <= touchValid;
		end
	end

	// top y bit picks the row, top two x bits the column
	// only meaningful while hitValid is high
	always_ff @(posedge Clock) begin
		hitTile <= {touchY[11], touchX[11:10]};
	end

endmodule

// File: rtl/panelPkg.sv
// touch panel and seven-segment display definitions
// digit codes, tick period and the hex glyph table

package panelPkg;

	// raw touch-panel coordinate
	typedef logic [11:0] touchCoord;

	// one second at 50 MHz
	localparam int unsigned defaultTickCycles = 50_000_000;

	// 0 to 15 show a hex glyph
	typedef logic [4:0] digitCode;
	localparam digitCode blankDigit = 5'h1F;

	localparam int digitCount = 8;

	// active low, segment a in bit 0
	typedef logic [6:0] segmentPattern;

	localparam segmentPattern hexGlyph [16] = '{
		7'h40, // 0
		7'h79, // 1
		7'h24, // 2
		7'h30, // 3
		7'h19, // 4
		7'h12, // 5
		7'h02, // 6
		7'h78, // 7
		7'h00, // 8
		7'h10, // 9
		7'h08, // A
		7'h03, // b
		7'h46, // C
		7'h21, // d
		7'h06, // E
		7'h0E  // F
	};

endpackage

// File: rtl/screenPkg.sv
// screen geometry and tile types for the colour tile board
// two rows of four tiles on an 800x480 panel

package screenPkg;

	// two rows of four
	localparam int tileCount = 8;

	// bit 2 is the row, bits 1:0 the column
	typedef logic [2:0] tileIndex;

	// bit 2 red, bit 1 green, bit 0 blue
	typedef logic [2:0] tileColour;

	typedef logic [7:0] colourLevel;
	typedef logic [9:0] pixelCoord;

	// tile and screen size in pixels
	localparam pixelCoord tileWidth = 10'd200;
	localparam pixelCoord tileHeight = 10'd240;
	localparam pixelCoord screenWidth = 10'd800;
	localparam pixelCoord screenHeight = 10'd480;

endpackage
